// ==== verilog.f ====
common/trellisPkg.sv
common/metricPkg.sv
acs/decayMult10x8.sv
acs/acsMuxLut.sv
acs/acsButterfly.sv
acs/acsCtrl.sv
src/trellisAcsTop.sv
tb/trellisAcs_checker.sv
tb/tbTrellisAcs.sv

// ==== Makefile ====
# Verilator build and run of the trellis ACS testbench.
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tbTrellisAcs
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Result comes from the log, not from the exit code of the run.
test: $(SIM_BIN)
	@./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "No final result line in $(LOG)"; \
		exit 1; \
	else \
		echo "Run clean, see $(LOG)"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tbTrellisAcs.sv ====
`timescale 1ns/10ps

module tbTrellisAcs
    import trellisPkg::*;
    import metricPkg::*;
();

    localparam int ACS_BITS = 8;
    localparam int MET_MAX  = (1 << (ACS_BITS - 1)) - 1;
    localparam logic [ACS_BITS-1:0] MOST_NEG = {1'b1, {(ACS_BITS - 1){1'b0}}};

    // Symbols per test. The watchdog is sized from these.
    localparam int N_UNITY = 40;
    localparam int N_B2B   = 200;
    localparam int N_POS   = 30;
    localparam int N_NEG   = 30;
    localparam int N_DECAY = 12;
    localparam int N_BEST  = 60;
    localparam int TOTAL_SYMBOLS = N_UNITY + N_B2B + N_POS + N_NEG + N_DECAY + N_BEST;
    localparam int WATCHDOG_NS   = (TOTAL_SYMBOLS * 20 + 500) * 10;

    typedef logic [2*NUM_STATES-1:0][ACS_BITS-1:0] branchVecT;
    typedef logic [NUM_STATES-1:0][ACS_BITS-1:0]   metricVecT;

    logic                  clk;
    logic                  arstN;
    logic                  symEn;
    branchVecT             branchMet;
    logic [DECAY_BITS-1:0] decayFactor;
    metricVecT             accMetOut;
    logic [NUM_STATES-1:0] decisions;
    logic [STATE_BITS-1:0] bestState;
    logic                  metValid;

    integer seed;
    int     errCount     = 0;
    int     checkCount   = 0;
    int     testNum      = 0;
    int     testErrStart = 0;
    string  testName;
    logic   strobeSeen   = 1'b0;

    // Model state holds the winners of the last symbol before decay.
    int                    rawMet [NUM_STATES];
    logic                  modelEven;
    metricVecT             rawQ [$];
    logic [NUM_STATES-1:0] decQ [$];

    trellisAcsTop #(
        .ACS_BITS (ACS_BITS)
    ) u_dut (
        .clk         (clk),
        .arstN       (arstN),
        .symEn       (symEn),
        .branchMet   (branchMet),
        .decayFactor (decayFactor),
        .accMetOut   (accMetOut),
        .decisions   (decisions),
        .bestState   (bestState),
        .metValid    (metValid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int clipMetric(input int val);
        if (val > MET_MAX) begin
            return MET_MAX;
        end
        if (val < -MET_MAX) begin
            return -MET_MAX;    // Most negative code is never produced.
        end
        return val;
    endfunction

    // Multiply by df/128, round half up, then clip.
    function automatic int decayModel(input int met, input int df);
        return clipMetric((met * df + 64) >>> 7);
    endfunction

    function automatic int predIndex(input int s, input int c, input logic even);
        if (even) begin
            return (2 * s + c) % NUM_STATES;
        end
        return (c != 0) ? (s ^ 2) : s;
    endfunction

    task automatic applySymbol(input branchVecT bm, input int df);
        int                    fb [NUM_STATES];
        int                    c0;
        int                    c1;
        metricVecT             nextRaw;
        logic [NUM_STATES-1:0] dec;
        for (int s = 0; s < NUM_STATES; s++) begin
            fb[s] = decayModel(rawMet[s], df);
        end
        for (int s = 0; s < NUM_STATES; s++) begin
            c0 = clipMetric(fb[predIndex(s, 0, modelEven)] + $signed(bm[2*s]));
            c1 = clipMetric(fb[predIndex(s, 1, modelEven)] + $signed(bm[2*s+1]));
            dec[s]     = (c1 > c0);     // Tie keeps choice 0.
            nextRaw[s] = ACS_BITS'(dec[s] ? c1 : c0);
            rawMet[s]  = dec[s] ? c1 : c0;
        end
        modelEven = !modelEven;
        rawQ.push_back(nextRaw);
        decQ.push_back(dec);
    endtask

    // ----------------------------------------
    // Checks and reporting
    // ----------------------------------------
    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            errCount++;
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
        end
    endtask

    task automatic reportError(input string msg);
        errCount++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic checkResult();
        metricVecT             raw;
        logic [NUM_STATES-1:0] dec;
        logic [ACS_BITS-1:0]   expMet;
        int                    outVal [NUM_STATES];
        int                    best;
        raw  = rawQ.pop_front();
        dec  = decQ.pop_front();
        best = 0;
        for (int s = 0; s < NUM_STATES; s++) begin
            // Output decays with the factor present now.
            outVal[s] = decayModel(int'($signed(raw[s])), int'(decayFactor));
            expMet    = ACS_BITS'(outVal[s]);
            checkValue($sformatf("accMetOut[%0d]", s), 32'(expMet), 32'(accMetOut[s]));
            if (accMetOut[s] == MOST_NEG) begin
                reportError($sformatf("accMetOut[%0d] shows the most negative code", s));
            end
            if (outVal[s] > outVal[best]) begin
                best = s;
            end
        end
        checkValue("decisions", 32'(dec), 32'(decisions));
        checkValue("bestState", 32'(best), 32'(bestState));
    endtask

    task automatic checkAllMetrics(input int expVal);
        logic [ACS_BITS-1:0] expMet;
        expMet = ACS_BITS'(expVal);
        for (int s = 0; s < NUM_STATES; s++) begin
            checkValue($sformatf("accMetOut[%0d]", s), 32'(expMet), 32'(accMetOut[s]));
        end
    endtask

    // Strobe sampled at the edge. metValid is due one cycle later.
    initial begin
        forever begin
            @(posedge clk);
            strobeSeen = symEn;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (arstN) begin
                if (metValid && !strobeSeen) begin
                    reportError("metValid rose without a symbol strobe");
                end else if (strobeSeen && !metValid) begin
                    reportError("symbol strobe was not followed by metValid");
                    if (rawQ.size() != 0) begin
                        void'(rawQ.pop_front());
                        void'(decQ.pop_front());
                    end
                end else if (metValid) begin
                    if (rawQ.size() == 0) begin
                        reportError("metValid with no symbol left in the model");
                    end else begin
                        checkResult();
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    function automatic int randRange(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic branchVecT randBranch(input int lo, input int hi);
        branchVecT bm;
        for (int b = 0; b < 2 * NUM_STATES; b++) begin
            bm[b] = ACS_BITS'(randRange(lo, hi));
        end
        return bm;
    endfunction

    task automatic sendSymbol(input branchVecT bm, input int df);
        symEn       = 1'b1;
        branchMet   = bm;
        decayFactor = DECAY_BITS'(df);
        applySymbol(bm, df);
        @(posedge clk);
        #1;
    endtask

    task automatic idleCycles(input int n);
        symEn = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic startTest(input string name);
        testNum++;
        testName     = name;
        testErrStart = errCount;
    endtask

    task automatic endTest();
        int waitCycles;
        symEn      = 1'b0;
        waitCycles = 0;
        while (rawQ.size() != 0 && waitCycles < 8) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (rawQ.size() != 0) begin
            reportError("symbol results still pending, metValid never came");
            rawQ.delete();
            decQ.delete();
        end
        idleCycles(1);
        $display("Test %0d (%s) finished: %0d errors", testNum, testName,
                 errCount - testErrStart);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        seed        = 32'h6662;
        arstN       = 1'b0;
        symEn       = 1'b0;
        branchMet   = '0;
        decayFactor = DECAY_BITS'(128);
        modelEven   = 1'b1;
        for (int s = 0; s < NUM_STATES; s++) begin
            rawMet[s] = 0;
        end
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;

        startTest("reset and unity decay");
        checkAllMetrics(0);
        checkValue("decisions", 32'(0), 32'(decisions));
        checkValue("bestState", 32'(0), 32'(bestState));
        checkValue("metValid", 32'(0), 32'(metValid));
        for (int i = 0; i < N_UNITY; i++) begin
            sendSymbol(randBranch(-16, 15), 128);
            idleCycles(randRange(1, 3));    // Spaced strobes.
        end
        endTest();

        startTest("back-to-back strobes");
        for (int i = 0; i < N_B2B; i++) begin
            sendSymbol(randBranch(-MET_MAX - 1, MET_MAX), randRange(96, 160));
        end
        endTest();

        startTest("positive saturation");
        for (int i = 0; i < N_POS; i++) begin
            sendSymbol(randBranch(100, MET_MAX), 128);
        end
        endTest();
        checkAllMetrics(MET_MAX);
        checkValue("decisions", 32'(0), 32'(decisions));

        startTest("negative saturation");
        for (int i = 0; i < N_NEG; i++) begin
            sendSymbol(randBranch(-MET_MAX - 1, -100), 255);
        end
        endTest();
        checkAllMetrics(-MET_MAX);
        checkValue("decisions", 32'(0), 32'(decisions));

        startTest("decay toward zero");
        for (int i = 0; i < N_DECAY; i++) begin
            sendSymbol('0, 64);     // Halves per symbol.
        end
        endTest();
        checkAllMetrics(0);

        startTest("best state search");
        for (int i = 0; i < N_BEST; i++) begin
            if (i % 2 == 0) begin
                sendSymbol(randBranch(0, 1) << 3, 128);     // Only 0 or 8 for many ties.
            end else begin
                sendSymbol(randBranch(-20, 20), 128);
            end
        end
        endTest();

        errCount += u_dut.u_checker.failValid + u_dut.u_checker.failMostNeg
                    + u_dut.u_checker.failPhase;
        $display("Tests: %0d, checks: %0d, errors: %0d", testNum, checkCount, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== tb/trellisAcs_checker.sv ====
`timescale 1ns/10ps

module trellisAcs_checker
    import trellisPkg::*;
#(
    parameter int ACS_BITS = 8
) (
    input logic                                clk,
    input logic                                arstN,
    input logic                                symEn,
    input logic                                symEnEven,
    input logic                                metValid,
    input logic [NUM_STATES-1:0][ACS_BITS-1:0] accMetOut
);

    localparam logic [ACS_BITS-1:0] MOST_NEG = {1'b1, {(ACS_BITS - 1){1'b0}}};

    int failValid   = 0;
    int failMostNeg = 0;
    int failPhase   = 0;

    function automatic logic hasMostNeg(input logic [NUM_STATES-1:0][ACS_BITS-1:0] met);
        logic found;
        found = 1'b0;
        for (int s = 0; s < NUM_STATES; s++) begin
            found = found | (met[s] == MOST_NEG);
        end
        return found;
    endfunction

    // ----------------------------------------
    // Control and saturation properties
    // ----------------------------------------
    validFollowsSym: assert property (
        @(posedge clk) disable iff (!arstN) metValid == $past(symEn)
    ) else begin
        $error("metValid does not follow symEn by one cycle");
        failValid++;
    end

    noMostNegative: assert property (
        @(posedge clk) disable iff (!arstN) !hasMostNeg(accMetOut)
    ) else begin
        $error("accMetOut holds the most negative code");
        failMostNeg++;
    end

    // Phase flips on each strobe and holds otherwise.
    phaseTogglesOnSym: assert property (
        @(posedge clk) disable iff (!arstN) symEnEven == ($past(symEnEven) ^ $past(symEn))
    ) else begin
        $error("phase did not toggle exactly once per symEn");
        failPhase++;
    end

endmodule

bind trellisAcsTop trellisAcs_checker #(
    .ACS_BITS (ACS_BITS)
) u_checker (
    .clk       (clk),
    .arstN     (arstN),
    .symEn     (symEn),
    .symEnEven (symEnEven),
    .metValid  (metValid),
    .accMetOut (accMetOut)
);

// ==== src/trellisAcsTop.sv ====
`timescale 1ns/10ps

module trellisAcsTop
    import trellisPkg::*;
    import metricPkg::*;
#(
    parameter int ACS_BITS = 8
) (
    input  logic                                   clk,
    input  logic                                   arstN,
    input  logic                                   symEn,
    input  logic [2*NUM_STATES-1:0][ACS_BITS-1:0]  branchMet,
    input  logic [DECAY_BITS-1:0]                  decayFactor,
    output logic [NUM_STATES-1:0][ACS_BITS-1:0]    accMetOut,
    output logic [NUM_STATES-1:0]                  decisions,
    output logic [STATE_BITS-1:0]                  bestState,
    output logic                                   metValid
);

    logic                                symEnEven;
    logic                                lastEven;
    logic [NUM_STATES-1:0][ACS_BITS-1:0] accMet_45;
    logic [NUM_STATES-1:0][ACS_BITS-1:0] accMet_54;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    acsCtrl #(
        .ACS_BITS (ACS_BITS)
    ) u_ctrl (
        .clk       (clk),
        .arstN     (arstN),
        .symEn     (symEn),
        .accMuxOut (accMetOut),
        .symEnEven (symEnEven),
        .lastEven  (lastEven),
        .metValid  (metValid),
        .bestState (bestState)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    acsButterfly #(
        .ACS_BITS (ACS_BITS)
    ) u_bfly (
        .clk       (clk),
        .arstN     (arstN),
        .symEn     (symEn),
        .symEnEven (symEnEven),
        .branchMet (branchMet),
        .accMuxOut (accMetOut),     // Feedback path.
        .accMet_45 (accMet_45),
        .accMet_54 (accMet_54),
        .decisions (decisions)
    );

    // Mux follows the phase already registered, not the next one.
    acsMuxLut #(
        .ACS_BITS (ACS_BITS)
    ) u_mux (
        .decayFactor (decayFactor),
        .symEnEven   (lastEven),
        .accMet_45   (accMet_45),
        .accMet_54   (accMet_54),
        .accMuxOut   (accMetOut)
    );

endmodule

// ==== acs/acsCtrl.sv ====
`timescale 1ns/10ps

module acsCtrl
    import trellisPkg::*;
#(
    parameter int ACS_BITS = 8
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                symEn,
    input  logic [NUM_STATES-1:0][ACS_BITS-1:0] accMuxOut,
    output logic                                symEnEven,
    output logic                                lastEven,
    output logic                                metValid,
    output logic [STATE_BITS-1:0]               bestState
);

    trellisPhaseT             phaseQ;
    logic [ACS_BITS-1:0]      bestVal;

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phaseQ   <= PHASE_45;
            lastEven <= 1'b1;
            metValid <= 1'b0;
        end else begin
            metValid <= symEn;      // Result strobe trails symEn by one cycle.
            if (symEn) begin
                phaseQ   <= (phaseQ == PHASE_45) ? PHASE_54 : PHASE_45;
                lastEven <= symEnEven;  // Phase of symbol being registered.
            end
        end
    end

    assign symEnEven = (phaseQ == PHASE_45);

    // ----------------------------------------
    // Best state search
    // ----------------------------------------
    // Strict compare keeps the lowest index on a tie.
    always_comb begin
        bestState = '0;
        bestVal   = accMuxOut[0];
        for (int s = 1; s < NUM_STATES; s++) begin
            if ($signed(accMuxOut[s]) > $signed(bestVal)) begin
                bestState = STATE_BITS'(s);
                bestVal   = accMuxOut[s];
            end
        end
    end

endmodule

// ==== acs/acsButterfly.sv ====
`timescale 1ns/10ps

module acsButterfly
    import trellisPkg::*;
    import metricPkg::*;
#(
    parameter int ACS_BITS = 8
) (
    input  logic                                   clk,
    input  logic                                   arstN,
    input  logic                                   symEn,
    input  logic                                   symEnEven,
    input  logic [2*NUM_STATES-1:0][ACS_BITS-1:0]  branchMet,
    input  logic [NUM_STATES-1:0][ACS_BITS-1:0]    accMuxOut,
    output logic [NUM_STATES-1:0][ACS_BITS-1:0]    accMet_45,
    output logic [NUM_STATES-1:0][ACS_BITS-1:0]    accMet_54,
    output logic [NUM_STATES-1:0]                  decisions
);

    // Candidates per state and choice, then the winner per state.
    logic [NUM_STATES-1:0][1:0][ACS_BITS-1:0] cand45;
    logic [NUM_STATES-1:0][1:0][ACS_BITS-1:0] cand54;
    logic [NUM_STATES-1:0][ACS_BITS-1:0]      win45;
    logic [NUM_STATES-1:0][ACS_BITS-1:0]      win54;
    logic [NUM_STATES-1:0]                    dec45;
    logic [NUM_STATES-1:0]                    dec54;

    // Saturating add of a path metric and a branch metric.
    function automatic logic [ACS_BITS-1:0] satAdd(
        input logic [ACS_BITS-1:0] met,
        input logic [ACS_BITS-1:0] br
    );
        logic signed [ACS_BITS:0] sum;
        sum = $signed(met) + $signed(br);
        return ACS_BITS'(satClip(int'(sum), ACS_BITS));
    endfunction

    // ----------------------------------------
    // Add and compare, both tables
    // ----------------------------------------
    always_comb begin
        for (int s = 0; s < NUM_STATES; s++) begin
            for (int c = 0; c < 2; c++) begin
                cand45[s][c] = satAdd(accMuxOut[PRED_45[s][c]], branchMet[2*s+c]);
                cand54[s][c] = satAdd(accMuxOut[PRED_54[s][c]], branchMet[2*s+c]);
            end

            // Choice 1 only wins when strictly larger.
            dec45[s] = $signed(cand45[s][1]) > $signed(cand45[s][0]);
            dec54[s] = $signed(cand54[s][1]) > $signed(cand54[s][0]);

            win45[s] = dec45[s] ? cand45[s][1] : cand45[s][0];
            win54[s] = dec54[s] ? cand54[s][1] : cand54[s][0];
        end
    end

    // ----------------------------------------
    // Select registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accMet_45 <= '0;
            accMet_54 <= '0;
            decisions <= '0;
        end else if (symEn) begin
            accMet_45 <= win45;
            accMet_54 <= win54;
            decisions <= symEnEven ? dec45 : dec54;   // Active table only.
        end
    end

endmodule

// ==== acs/acsMuxLut.sv ====
`timescale 1ns/10ps

module acsMuxLut
    import trellisPkg::*;
    import metricPkg::*;
#(
    parameter int ACS_BITS = 8
) (
    input  logic [DECAY_BITS-1:0]                decayFactor,
    input  logic                                 symEnEven,
    input  logic [NUM_STATES-1:0][ACS_BITS-1:0]  accMet_45,
    input  logic [NUM_STATES-1:0][ACS_BITS-1:0]  accMet_54,
    output logic [NUM_STATES-1:0][ACS_BITS-1:0]  accMuxOut
);

    logic [NUM_STATES-1:0][ACS_BITS-1:0] muxSel;
    logic [NUM_STATES-1:0][ACS_BITS:0]   decayOut;

    // ----------------------------------------
    // Phase select
    // ----------------------------------------
    // High picks the set of the even symbol just registered.
    assign muxSel = symEnEven ? accMet_45 : accMet_54;

    // ----------------------------------------
    // Decay per state
    // ----------------------------------------
    for (genvar s = 0; s < NUM_STATES; s++) begin : gDecay
        decayMult10x8 #(
            .ACS_BITS (ACS_BITS)
        ) u_decay (
            .a (muxSel[s]),
            .b (decayFactor),
            .p (decayOut[s])
        );
    end

    // ----------------------------------------
    // Output saturation
    // ----------------------------------------
    // Top two bits flag overflow; most negative code is clipped as well.
    always_comb begin
        for (int s = 0; s < NUM_STATES; s++) begin
            accMuxOut[s] = ACS_BITS'(satClip(int'($signed(decayOut[s])), ACS_BITS));
        end
    end

endmodule

// ==== acs/decayMult10x8.sv ====
`timescale 1ns/10ps

module decayMult10x8
    import metricPkg::*;
#(
    parameter int ACS_BITS = 8
) (
    input  logic signed [ACS_BITS-1:0]   a,
    input  logic        [DECAY_BITS-1:0] b,
    output logic signed [ACS_BITS:0]     p
);

    // Full product needs room for the sign of the unsigned factor.
    localparam int PROD_BITS = ACS_BITS + DECAY_BITS + 1;

    logic signed [PROD_BITS-1:0] prod;
    logic signed [PROD_BITS-1:0] prodRnd;
    logic signed [PROD_BITS-1:0] prodShr;

    assign prod    = a * $signed({1'b0, b});
    assign prodRnd = prod + PROD_BITS'(DECAY_ROUND);   // Round to nearest.
    assign prodShr = prodRnd >>> DECAY_SHIFT;

    // Factor stays below 2, so one extra bit holds the result.
    assign p = prodShr[ACS_BITS:0];

endmodule

// ==== common/metricPkg.sv ====
package metricPkg;

    // ----------------------------------------
    // Decay scaling
    // ----------------------------------------
    localparam int DECAY_BITS  = 8;     // Unsigned fraction width.
    localparam int DECAY_SHIFT = 7;     // 128 is unity.
    localparam int DECAY_ROUND = 64;    // Half an LSB after the shift.

    // ----------------------------------------
    // Saturation limits
    // ----------------------------------------
    // Largest positive metric for a given width.
    function automatic int satHi(input int bits);
        return (1 << (bits - 1)) - 1;
    endfunction

    // Lowest metric is one above the most negative code.
    function automatic int satLo(input int bits);
        return 1 - (1 << (bits - 1));
    endfunction

    // Clips a wide value into the symmetric metric range.
    function automatic int satClip(input int val, input int bits);
        if (val > satHi(bits)) begin
            return satHi(bits);
        end
        if (val < satLo(bits)) begin
            return satLo(bits);     // Also catches the most negative code.
        end
        return val;
    endfunction

endpackage

// ==== common/trellisPkg.sv ====
package trellisPkg;

    // ----------------------------------------
    // State space
    // ----------------------------------------
    localparam int NUM_STATES = 4;
    localparam int STATE_BITS = $clog2(NUM_STATES);

    // Even symbols run the 45 trellis, odd symbols the 54 trellis.
    typedef enum logic {
        PHASE_45 = 1'b0,
        PHASE_54 = 1'b1
    } trellisPhaseT;

    // ----------------------------------------
    // Predecessor tables by state and choice
    // ----------------------------------------
    // In phase 45 state s comes from 2s mod 4 and 2s+1 mod 4.
    localparam logic [NUM_STATES-1:0][1:0][STATE_BITS-1:0] PRED_45 = {
        2'd3, 2'd2,     // State 3.
        2'd1, 2'd0,     // State 2.
        2'd3, 2'd2,     // State 1.
        2'd1, 2'd0      // State 0.
    };

    // In phase 54 state s comes from s and s xor 2.
    localparam logic [NUM_STATES-1:0][1:0][STATE_BITS-1:0] PRED_54 = {
        2'd1, 2'd3,     // State 3.
        2'd0, 2'd2,     // State 2.
        2'd3, 2'd1,     // State 1.
        2'd2, 2'd0      // State 0.
    };

    // Branch metric for state s and choice c sits at index 2s+c.

endpackage
